//--- common/cfg_consts.svh
// config register crossing constants
// widths and depths shared by the package and the RTL

`ifndef CFG_CONSTS_SVH
`define CFG_CONSTS_SVH

//////////////////////////////////////////////////
// datapath word
//////////////////////////////////////////////////
`define CFG_DWIDTH 16 // bits per config word

//////////////////////////////////////////////////
// crossing and register file
//////////////////////////////////////////////////
`define CFG_SYNC_STAGES 4 // flops per synchronizer direction
`define CFG_NUM_REGS 4    // registers updated per packet

`endif

//--- common/cfg_pkg.sv
// config register crossing types
// word, packet, index and register array types plus the crossing FSM states

`default_nettype none

`include "cfg_consts.svh"

package cfg_pkg;

  // one config word as seen on the source stream
  typedef logic [`CFG_DWIDTH-1:0] cfg_word_t;

  // word plus last flag, msb is last
  typedef logic [`CFG_DWIDTH:0] cfg_packet_t;

  // word position, one extra count marks overflow
  typedef logic [$clog2(`CFG_NUM_REGS+1)-1:0] cfg_idx_t;

  // full register set, entry 0 in the low bits
  typedef cfg_word_t [`CFG_NUM_REGS-1:0] cfg_regs_t;

  // destination side crossing controller
  typedef enum logic [1:0] {
    xfer_idle,         // no crossed word
    xfer_offer,        // word crossed, waiting for loader
    xfer_wait_release  // ack high until req drops
  } cfg_xfer_state_t;

endpackage

`default_nettype wire

//--- cdc/cfg_handshake_sync.sv
// four-phase req/ack handshake synchronizer
// moves one held data word from src_clk to dest_clk per handshake

`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_handshake_sync #(
  parameter int WIDTH = 17 // payload width
) (
  input  logic             src_clk,
  input  logic             src_reset,
  input  logic             src_send, // level, held until src_rcv
  input  logic [WIDTH-1:0] src_in,
  output logic             src_rcv,

  input  logic             dest_clk,
  input  logic             dest_reset,
  input  logic             dest_ack, // level, held until dest_req falls
  output logic             dest_req,
  output logic [WIDTH-1:0] dest_out
);

  localparam int STAGES = `CFG_SYNC_STAGES;

  //////////////////////////////////////////////////
  // source domain
  //////////////////////////////////////////////////
  logic              src_req_q;    // registered send, the only bit that crosses as req
  logic [WIDTH-1:0]  src_hold;     // payload held for the whole handshake
  logic [STAGES-1:0] ack_sync;     // ack chain into src_clk

  always_ff @(posedge src_clk) begin
    // capture on the send rise, same edge that launches req
    if (src_send & ~src_req_q) begin
      src_hold <= src_in;
    end
    if (src_reset) begin
      src_req_q <= 1'b0;
      ack_sync  <= '0;
    end else begin
      src_req_q <= src_send;
      ack_sync  <= {ack_sync[STAGES-2:0], dest_ack};
    end
  end

  assign src_rcv = ack_sync[STAGES-1]; // ack seen after STAGES src clocks

  //////////////////////////////////////////////////
  // destination domain
  //////////////////////////////////////////////////
  logic [STAGES-1:0] req_sync; // req chain into dest_clk, last stage is dest_req

  always_ff @(posedge dest_clk) begin
    // src_hold has been stable for several dest clocks by now
    // load it on the same edge that raises dest_req
    if (req_sync[STAGES-2] & ~req_sync[STAGES-1]) begin
      dest_out <= src_hold;
    end
    if (dest_reset) begin
      req_sync <= '0;
    end else begin
      req_sync <= {req_sync[STAGES-2:0], src_req_q};
    end
  end

  assign dest_req = req_sync[STAGES-1];

endmodule

`default_nettype wire

//--- cdc/cfg_reg_cdc.sv
// config word crossing
// valid/ready back-pressure on src_clk, req/ack controller on dest_clk

`timescale 1ns/1ps
`default_nettype none

module cfg_reg_cdc (
  input  logic              src_clk,
  input  logic              src_reset,
  input  logic              src_valid,
  input  cfg_pkg::cfg_word_t src_data,
  input  logic              src_last,
  output logic              src_ready,

  input  logic              dest_clk,
  input  logic              dest_reset,
  input  logic              word_ready, // loader can take a word
  output logic              word_valid, // one-cycle pulse per crossed word
  output cfg_pkg::cfg_word_t word_data,
  output logic              word_last
);

  import cfg_pkg::*;

  //////////////////////////////////////////////////
  // source side back-pressure
  //////////////////////////////////////////////////
  logic        src_send;
  logic        src_rcv;
  cfg_packet_t src_packet; // last flag on top of the word

  // no new word in reset or while a handshake is open in either phase
  assign src_ready = ~(src_send | src_rcv | src_reset);

  always_ff @(posedge src_clk) begin
    if (src_valid & src_ready) begin
      src_packet <= {src_last, src_data};
    end
    if (src_reset) begin
      src_send <= 1'b0;
    end else begin
      if (src_valid & src_ready) begin
        src_send <= 1'b1; // start handshake
      end else if (src_send & src_rcv) begin
        src_send <= 1'b0; // destination took it, release req
      end
    end
  end

  //////////////////////////////////////////////////
  // destination side req/ack control
  //////////////////////////////////////////////////
  logic            dest_req;
  logic            dest_ack;
  cfg_packet_t     dest_packet;
  cfg_xfer_state_t xfer_state;

  assign {word_last, word_data} = dest_packet; // held by the synchronizer

  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      xfer_state <= xfer_idle;
      dest_ack   <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0; // pulse only
      case (xfer_state)
        xfer_idle: begin
          if (dest_req) begin
            xfer_state <= xfer_offer; // new word is on dest_packet
          end
        end
        xfer_offer: begin
          // ack is withheld while the loader is busy
          if (word_ready) begin
            word_valid <= 1'b1;
            dest_ack   <= 1'b1;
            xfer_state <= xfer_wait_release;
          end
        end
        xfer_wait_release: begin
          if (~dest_req) begin
            dest_ack   <= 1'b0; // closes the four-phase cycle
            xfer_state <= xfer_idle;
          end
        end
        default: xfer_state <= xfer_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // synchronizer
  //////////////////////////////////////////////////
  cfg_handshake_sync #(
    .WIDTH($bits(cfg_packet_t))
  ) u_sync (
    .src_clk    (src_clk),
    .src_reset  (src_reset),
    .src_send   (src_send),
    .src_in     (src_packet),
    .src_rcv    (src_rcv),
    .dest_clk   (dest_clk),
    .dest_reset (dest_reset),
    .dest_ack   (dest_ack),
    .dest_req   (dest_req),
    .dest_out   (dest_packet)
  );

endmodule

`default_nettype wire

//--- hdl/cfg_shadow_load.sv
// shadow register loader
// places the words of one packet by position and holds the set until commit

`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_shadow_load (
  input  logic               dest_clk,
  input  logic               dest_reset,

  input  logic               word_valid,
  input  cfg_pkg::cfg_word_t word_data,
  input  logic               word_last,
  output logic               word_ready,

  output logic               commit_pending, // finished packet waiting
  output cfg_pkg::cfg_regs_t shadow_regs,
  output logic               shadow_dropped, // packet ran past the last register
  input  logic               commit_done     // active side took the set
);

  import cfg_pkg::*;

  localparam cfg_idx_t IDX_FULL = cfg_idx_t'(`CFG_NUM_REGS); // saturation count

  cfg_idx_t word_idx; // position of the next word in the packet

  // stall the crossing while a packet is waiting to be committed
  assign word_ready = ~commit_pending;

  //////////////////////////////////////////////////
  // word placement
  //////////////////////////////////////////////////
  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      word_idx       <= '0;
      commit_pending <= 1'b0;
      shadow_dropped <= 1'b0;
      shadow_regs    <= '0; // same start value as the active set
    end else if (commit_done) begin
      // next packet starts at register 0 again
      // shadow contents stay so short packets keep the old values
      word_idx       <= '0;
      commit_pending <= 1'b0;
      shadow_dropped <= 1'b0;
    end else if (word_valid) begin
      if (word_idx < IDX_FULL) begin
        shadow_regs[word_idx] <= word_data;
        word_idx              <= word_idx + 1'b1; // stops at IDX_FULL
      end else begin
        shadow_dropped <= 1'b1; // extra word, discarded
      end
      if (word_last) begin
        commit_pending <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cfg_active_regs.sv
// active config registers
// switch the whole shadow set at once when the datapath allows it

`timescale 1ns/1ps
`default_nettype none

module cfg_active_regs (
  input  logic               dest_clk,
  input  logic               dest_reset,
  input  logic               dest_hold,      // datapath forbids a switch

  input  logic               commit_pending,
  input  cfg_pkg::cfg_regs_t shadow_regs,
  input  logic               shadow_dropped,
  output logic               commit_done,    // pulse back to the loader

  output cfg_pkg::cfg_regs_t cfg_regs,
  output logic               cfg_update,     // one cycle, new cfg_regs visible
  output logic               cfg_dropped     // meaningful with cfg_update
);

  logic commit_go;

  // the loader still shows pending during the done pulse, skip that cycle
  assign commit_go = commit_pending & ~dest_hold & ~cfg_update;

  // done and update are the same event
  assign commit_done = cfg_update;

  //////////////////////////////////////////////////
  // atomic switch
  //////////////////////////////////////////////////
  always_ff @(posedge dest_clk) begin
    if (dest_reset) begin
      cfg_regs    <= '0;
      cfg_update  <= 1'b0;
      cfg_dropped <= 1'b0;
    end else begin
      cfg_update <= commit_go;
      if (commit_go) begin
        cfg_regs    <= shadow_regs;    // all registers in one edge
        cfg_dropped <= shadow_dropped;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cfg_cdc_top.sv
// config register crossing top
// src_clk word stream in, atomically updated register set out on dest_clk

`timescale 1ns/1ps
`default_nettype none

module cfg_cdc_top (
  // control side
  input  logic               src_clk,
  input  logic               src_reset,
  input  logic               src_valid,
  input  cfg_pkg::cfg_word_t src_data,
  input  logic               src_last,
  output logic               src_ready,

  // datapath side
  input  logic               dest_clk,
  input  logic               dest_reset,
  input  logic               dest_hold,
  output cfg_pkg::cfg_regs_t cfg_regs,
  output logic               cfg_update,
  output logic               cfg_dropped
);

  import cfg_pkg::*;

  //////////////////////////////////////////////////
  // internal links
  //////////////////////////////////////////////////
  logic      word_valid;
  cfg_word_t word_data;
  logic      word_last;
  logic      word_ready;

  logic      commit_pending;
  cfg_regs_t shadow_regs;
  logic      shadow_dropped;
  logic      commit_done;

  cfg_reg_cdc u_cdc (
    .src_clk    (src_clk),
    .src_reset  (src_reset),
    .src_valid  (src_valid),
    .src_data   (src_data),
    .src_last   (src_last),
    .src_ready  (src_ready),
    .dest_clk   (dest_clk),
    .dest_reset (dest_reset),
    .word_ready (word_ready),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_last  (word_last)
  );

  cfg_shadow_load u_load (
    .dest_clk       (dest_clk),
    .dest_reset     (dest_reset),
    .word_valid     (word_valid),
    .word_data      (word_data),
    .word_last      (word_last),
    .word_ready     (word_ready),
    .commit_pending (commit_pending),
    .shadow_regs    (shadow_regs),
    .shadow_dropped (shadow_dropped),
    .commit_done    (commit_done)
  );

  cfg_active_regs u_active (
    .dest_clk       (dest_clk),
    .dest_reset     (dest_reset),
    .dest_hold      (dest_hold),
    .commit_pending (commit_pending),
    .shadow_regs    (shadow_regs),
    .shadow_dropped (shadow_dropped),
    .commit_done    (commit_done),
    .cfg_regs       (cfg_regs),
    .cfg_update     (cfg_update),
    .cfg_dropped    (cfg_dropped)
  );

endmodule

`default_nettype wire

//--- tb/cfg_cdc_chk.sv
// config crossing checker
// concurrent assertions on the source handshake and the update strobe

`timescale 1ns/1ps
`default_nettype none

module cfg_cdc_chk (
  input logic               src_clk,
  input logic               src_reset,
  input logic               src_valid,
  input logic               src_ready,
  input logic               dest_clk,
  input logic               dest_reset,
  input logic               dest_hold,
  input cfg_pkg::cfg_regs_t cfg_regs,
  input logic               cfg_update
);

  // back-pressure closes right after an accepted word
  assert property (@(posedge src_clk) disable iff (src_reset)
    (src_valid && src_ready) |=> !src_ready)
    else $error("src_ready high in the cycle after an accepted word");

  // strobe is one cycle wide
  assert property (@(posedge dest_clk) disable iff (dest_reset)
    cfg_update |=> !cfg_update)
    else $error("cfg_update high two cycles in a row");

  assert property (@(posedge dest_clk) disable iff (dest_reset)
    $rose(cfg_update) |-> !$past(dest_hold))
    else $error("cfg_update rose after dest_hold was high");

  // atomic switch, registers move only with the strobe
  assert property (@(posedge dest_clk) disable iff (dest_reset)
    !$stable(cfg_regs) |-> cfg_update)
    else $error("cfg_regs changed without cfg_update");

endmodule

bind cfg_cdc_top cfg_cdc_chk u_chk (
  .src_clk(src_clk), .src_reset(src_reset), .src_valid(src_valid),
  .src_ready(src_ready), .dest_clk(dest_clk), .dest_reset(dest_reset),
  .dest_hold(dest_hold), .cfg_regs(cfg_regs), .cfg_update(cfg_update)
);

`default_nettype wire

//--- tb/cfg_cdc_tb.sv
// config register crossing testbench
// random packets across src_clk/dest_clk, checked against a register model

`timescale 1ns/1ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_cdc_tb;

  import cfg_pkg::*;

  localparam int NUM_PACKETS    = 40;
  localparam int MAX_LEN        = 6;
  localparam int TIMEOUT_CYCLES = NUM_PACKETS * MAX_LEN * 60 + 10; // plus reset

  logic src_clk, src_reset, src_valid, src_last, src_ready;
  logic dest_clk, dest_reset, dest_hold, cfg_update, cfg_dropped;
  cfg_word_t src_data;
  cfg_regs_t cfg_regs;

  cfg_regs_t model_regs;    // expected active set after each packet
  cfg_regs_t exp_regs_q[$];
  logic      exp_drop_q[$];
  int        exp_len_q[$];
  int test_errs[1:5];
  int check_count, update_count, words_planned, words_crossed, short_seen, long_seen;
  int cycle_count, seed_ret;

  cfg_cdc_top u_dut (
    .src_clk(src_clk), .src_reset(src_reset), .src_valid(src_valid),
    .src_data(src_data), .src_last(src_last), .src_ready(src_ready),
    .dest_clk(dest_clk), .dest_reset(dest_reset), .dest_hold(dest_hold),
    .cfg_regs(cfg_regs), .cfg_update(cfg_update), .cfg_dropped(cfg_dropped)
  );

  initial begin
    dest_clk = 1'b0;
    forever #50 dest_clk = ~dest_clk;
  end

  initial begin
    src_clk = 1'b0;
    forever #85 src_clk = ~src_clk;
  end

  task automatic check_value(input int test, input string name,
                             input logic [63:0] expected, input logic [63:0] actual);
    check_count++;
    assert (expected === actual) else begin
      $display("FAIL %s expected %h got %h", name, expected, actual);
      test_errs[test]++;
    end
  endtask

  task automatic check_true(input int test, input logic cond, input string msg);
    check_count++;
    assert (cond) else begin
      $display("error: %s", msg);
      test_errs[test]++;
    end
  endtask

  task automatic report_test(input int test, input string name);
    $display("test %0d %s: %s (%0d errors)", test, name,
             (test_errs[test] == 0) ? "ok" : "failed", test_errs[test]);
  endtask

  // called at src_clk edge + 5 ns, returns at the edge + 5 ns after the handshake
  task automatic send_word(input cfg_word_t data, input logic last);
    int   gap;
    logic ready_seen;
    gap = $urandom % 4;
    repeat (gap) begin
      @(posedge src_clk);
      #5;
    end
    src_valid  = 1'b1;
    src_data   = data;
    src_last   = last;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      ready_seen = src_ready; // stable until the next edge
      @(posedge src_clk);
      #5;
    end
    src_valid = 1'b0;
  endtask

  task automatic send_packet(input int len);
    cfg_word_t data;
    logic      drop;
    drop = 1'b0;
    words_planned += len;
    for (int i = 0; i < len; i++) begin
      data = cfg_word_t'($urandom);
      send_word(data, i == len - 1);
      if (i < `CFG_NUM_REGS) model_regs[i] = data; // word i lands in entry i
      else drop = 1'b1;
    end
    exp_regs_q.push_back(model_regs);
    exp_drop_q.push_back(drop);
    exp_len_q.push_back(len);
  endtask

  // random hold level, new value every 1 to 8 dest cycles
  task automatic drive_hold();
    wait (!dest_reset);
    forever begin
      repeat (1 + $urandom % 8) @(posedge dest_clk);
      #5 dest_hold = ($urandom % 4) == 0;
    end
  endtask

  // words handed to the loader, one word_valid pulse each
  initial begin
    wait (!dest_reset);
    forever begin
      @(negedge dest_clk);
      if (u_dut.word_valid) words_crossed++;
    end
  end

  //////////////////////////////////////////////////
  // update monitor
  //////////////////////////////////////////////////
  initial begin
    cfg_regs_t last_exp, exp_regs;
    logic      prev_hold, exp_drop;
    int        len;
    last_exp = '0; // active set after reset
    wait (!dest_reset);
    @(negedge dest_clk);
    prev_hold = dest_hold; // value seen by the next rising edge
    forever begin
      @(negedge dest_clk);
      if (cfg_update) begin
        update_count++;
        check_true(5, !prev_hold, "cfg_update rose although dest_hold was high");
        check_true(2, exp_regs_q.size() > 0, "cfg_update with no packet waiting");
        if (exp_regs_q.size() > 0) begin
          exp_regs = exp_regs_q.pop_front();
          exp_drop = exp_drop_q.pop_front();
          len      = exp_len_q.pop_front();
          check_value(2, "cfg_regs", exp_regs, cfg_regs);
          check_value(2, "cfg_dropped", exp_drop, cfg_dropped);
          if (len < `CFG_NUM_REGS) begin
            short_seen++;
            for (int i = len; i < `CFG_NUM_REGS; i++)
              check_value(3, $sformatf("cfg_regs[%0d]", i), last_exp[i], cfg_regs[i]);
          end
          if (len > `CFG_NUM_REGS) begin
            long_seen++;
            check_value(4, "cfg_dropped", 1'b1, cfg_dropped);
            check_value(4, "cfg_regs", exp_regs, cfg_regs); // first four words only
          end else begin
            check_value(4, "cfg_dropped", 1'b0, cfg_dropped);
          end
          last_exp = exp_regs;
        end
      end
      prev_hold = dest_hold;
    end
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge dest_clk);
      cycle_count++;
    end
    $display("error: timeout after %0d dest cycles, %0d of %0d updates seen",
             cycle_count, update_count, NUM_PACKETS);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    logic ready_ok;
    int   total_errs;
    seed_ret   = $urandom(22);
    src_reset  = 1'b1;
    dest_reset = 1'b1;
    src_valid  = 1'b0;
    src_data   = '0;
    src_last   = 1'b0;
    dest_hold  = 1'b0;
    model_regs = '0;
    for (int t = 1; t <= 5; t++) test_errs[t] = 0;
    fork
      drive_hold();
    join_none
    fork
      begin
        repeat (10) @(posedge src_clk);
        #5;
        check_value(1, "src_ready", 1'b0, src_ready); // no transfer in reset
        src_reset = 1'b0;
      end
      begin
        repeat (10) @(posedge dest_clk);
        #5 dest_reset = 1'b0;
      end
    join

    @(negedge dest_clk);
    check_value(1, "cfg_regs", '0, cfg_regs);
    check_value(1, "cfg_update", 1'b0, cfg_update);
    ready_ok = 1'b0;
    @(posedge src_clk);
    #5;
    for (int n = 0; n < 20 && !ready_ok; n++) begin
      ready_ok = src_ready;
      if (!ready_ok) begin
        @(posedge src_clk);
        #5;
      end
    end
    check_true(1, ready_ok, "src_ready never went high after reset");
    report_test(1, "reset state");

    for (int p = 0; p < NUM_PACKETS; p++) send_packet(1 + $urandom % MAX_LEN);
    wait (update_count == NUM_PACKETS);
    repeat (40) @(posedge dest_clk); // room for a stray update

    check_true(3, short_seen > 0, "no short packet was committed");
    check_true(4, long_seen > 0, "no overlong packet was committed");
    check_true(5, update_count == NUM_PACKETS, "number of updates differs from packets sent");
    check_true(5, words_crossed == words_planned, "not every sent word was accepted");
    report_test(2, "updates in order");
    report_test(3, "short packets keep upper registers");
    report_test(4, "overlong packets dropped");
    report_test(5, "hold and word count");

    total_errs = 0;
    for (int t = 1; t <= 5; t++) total_errs += test_errs[t];
    $display("checks %0d, errors %0d, updates %0d, words %0d",
             check_count, total_errs, update_count, words_crossed);
    if (total_errs == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/cfg_pkg.sv
cdc/cfg_handshake_sync.sv
cdc/cfg_reg_cdc.sv
hdl/cfg_shadow_load.sv
hdl/cfg_active_regs.sv
hdl/cfg_cdc_top.sv
tb/cfg_cdc_chk.sv
tb/cfg_cdc_tb.sv

//--- Bender.yml
package:
  name: cfg_cdc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cfg_pkg.sv
      - cdc/cfg_handshake_sync.sv
      - cdc/cfg_reg_cdc.sv
      - hdl/cfg_shadow_load.sv
      - hdl/cfg_active_regs.sv
      - hdl/cfg_cdc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/cfg_cdc_chk.sv
      - tb/cfg_cdc_tb.sv
